// File: Makefile
VERILATOR ?= verilator
FILELIST  ?= filelist.f
TB_TOP    ?= mmsa_tb
RTL_TOP   ?= mmsa_top
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Test passed
LINT_FLAGS ?= --lint-only -Wall --timing
SIM_FLAGS  ?= --binary --timing -Wno-fatal

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

build:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TB_TOP) \
		--Mdir $(BUILD_DIR) -o V$(TB_TOP)

sim: build
	./$(BUILD_DIR)/V$(TB_TOP) | tee $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG) || (echo "simulation did not pass" && exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: dv/mmsa_tb.sv
`timescale 1ns/1ps
`include "mmsa_macros.svh"

module mmsa_tb;

    localparam int CLK_PERIOD     = 4;
    localparam int TIMEOUT_CYCLES = 5000;

    logic       clk;
    logic       rst_n;
    logic       i_in_valid;
    logic       i_matrix;
    logic [1:0] i_matrix_size;
    logic       i_in_valid2;
    logic       i_i_mat_idx;
    logic       i_w_mat_idx;
    logic       o_out_valid;
    logic       o_out_value;

    logic [31:0] lfsr_state;
    int          errors;
    int          checks;
    int          timeouts;
    int          neg_seen;
    int          zero_seen;
    int          cur_dim;
    int          n_diag;

    // model copy of both banks, [matrix][row][col]
    logic signed [`MMSA_ELEM_W-1:0] x_mdl [`MMSA_NUM_MATS][`MMSA_MAX_DIM][`MMSA_MAX_DIM];
    logic signed [`MMSA_ELEM_W-1:0] w_mdl [`MMSA_NUM_MATS][`MMSA_MAX_DIM][`MMSA_MAX_DIM];
    logic signed [`MMSA_ACC_W-1:0]  exp_sum [`MMSA_NUM_DIAGS];
    int                             exp_len [`MMSA_NUM_DIAGS];
    logic                           got_bits [$];

    mmsa_top dut (
        .clk           (clk),
        .rst_n         (rst_n),
        .i_in_valid    (i_in_valid),
        .i_matrix      (i_matrix),
        .i_matrix_size (i_matrix_size),
        .i_in_valid2   (i_in_valid2),
        .i_i_mat_idx   (i_i_mat_idx),
        .i_w_mat_idx   (i_w_mat_idx),
        .o_out_valid   (o_out_valid),
        .o_out_value   (o_out_value)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // --------------------------------------------------
    // random source and reference model
    // --------------------------------------------------

    // galois lfsr, one step per bit
    function automatic logic rand_bit();
        logic out;
        out = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (out) begin
            lfsr_state = lfsr_state ^ 32'h8020_0003;
        end
        return out;
    endfunction

    function automatic logic [31:0] rand_bits(input int width);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < width; i++) begin
            v = {v[30:0], rand_bit()};
        end
        return v;
    endfunction

    // negative sums use the full width, zero still takes one bit
    function automatic int sum_length(input logic signed [`MMSA_ACC_W-1:0] v);
        logic [`MMSA_ACC_W-1:0] u;
        int                     len;
        if (v < 0) begin
            return `MMSA_ACC_W;
        end
        u = v;
        len = 1;
        while (len < `MMSA_ACC_W && (u >> len) != 0) begin
            len++;
        end
        return len;
    endfunction

    task automatic build_expected(input int xi, input int wi);
        longint acc [`MMSA_NUM_DIAGS];
        for (int d = 0; d < `MMSA_NUM_DIAGS; d++) begin
            acc[d] = 0;
        end
        for (int r = 0; r < cur_dim; r++) begin
            for (int c = 0; c < cur_dim; c++) begin
                for (int k = 0; k < cur_dim; k++) begin
                    acc[r + c] += longint'(x_mdl[xi][r][k]) * longint'(w_mdl[wi][k][c]);
                end
            end
        end
        n_diag = 2 * cur_dim - 1;
        for (int d = 0; d < n_diag; d++) begin
            exp_sum[d] = acc[d][`MMSA_ACC_W-1:0];
            exp_len[d] = sum_length(exp_sum[d]);
            if (exp_sum[d] < 0) neg_seen++;
            if (exp_sum[d] == 0) zero_seen++;
        end
    endtask

    // --------------------------------------------------
    // stimulus
    // --------------------------------------------------

    task automatic step();
        @(posedge clk);
        #1;
    endtask

    // X bank then W bank, row-major, msb first
    task automatic load_bank(input int dim, input bit zero_x0);
        logic signed [`MMSA_ELEM_W-1:0] elem;
        for (int bank = 0; bank < 2; bank++) begin
            for (int m = 0; m < `MMSA_NUM_MATS; m++) begin
                for (int r = 0; r < dim; r++) begin
                    for (int c = 0; c < dim; c++) begin
                        elem = `MMSA_ELEM_W'(rand_bits(`MMSA_ELEM_W));
                        if (zero_x0 && bank == 0 && m == 0) elem = '0;
                        if (bank == 0) x_mdl[m][r][c] = elem;
                        else w_mdl[m][r][c] = elem;
                        for (int b = `MMSA_ELEM_W - 1; b >= 0; b--) begin
                            step();
                            i_in_valid    = 1'b1;
                            i_matrix_size = (dim == 4) ? 2'b01 : 2'b00;
                            i_matrix      = elem[b];
                        end
                    end
                end
            end
        end
        step();
        i_in_valid = 1'b0;
        i_matrix   = 1'b0;
        repeat (3) step();
        cur_dim = dim;
    endtask

    task automatic send_index(input logic [1:0] xi, input logic [1:0] wi);
        for (int b = 1; b >= 0; b--) begin
            step();
            i_in_valid2 = 1'b1;
            i_i_mat_idx = xi[b];
            i_w_mat_idx = wi[b];
        end
        step();
        i_in_valid2 = 1'b0;
        i_i_mat_idx = 1'b0;
        i_w_mat_idx = 1'b0;
    endtask

    // --------------------------------------------------
    // collection and checking
    // --------------------------------------------------

    task automatic collect_frame(output bit ok);
        int wait_cnt;
        ok = 1'b0;
        got_bits.delete();
        wait_cnt = 0;
        @(negedge clk);
        while (!o_out_valid && wait_cnt < TIMEOUT_CYCLES) begin
            @(negedge clk);
            wait_cnt++;
        end
        if (!o_out_valid) begin
            errors++;
            timeouts++;
            $display("Error: timeout, o_out_valid never rose after the index phase");
            return;
        end
        wait_cnt = 0;
        while (o_out_valid && wait_cnt < TIMEOUT_CYCLES) begin
            got_bits.push_back(o_out_value);
            @(negedge clk);
            wait_cnt++;
        end
        if (o_out_valid) begin
            errors++;
            timeouts++;
            $display("Error: timeout, o_out_valid never fell at the end of the frame");
            return;
        end
        ok = 1'b1;
    endtask

    task automatic check_frame(input string name);
        int                     pos;
        int                     total;
        int                     len_got;
        logic [`MMSA_ACC_W-1:0] val_got;
        total = 0;
        for (int d = 0; d < n_diag; d++) begin
            total += `MMSA_LEN_W + exp_len[d];
        end
        checks++;
        if (got_bits.size() != total) begin
            errors++;
            $display("Fail %s frame cycles: expected %0d actual %0d", name, total, got_bits.size());
        end
        pos = 0;
        for (int d = 0; d < n_diag; d++) begin
            if (pos + `MMSA_LEN_W > got_bits.size()) break;
            len_got = 0;
            for (int b = 0; b < `MMSA_LEN_W; b++) begin
                len_got = (len_got << 1) | int'(got_bits[pos]);
                pos++;
            end
            checks++;
            if (len_got != exp_len[d]) begin
                errors++;
                $display("Fail %s diag %0d length: expected %0d actual %0d",
                         name, d, exp_len[d], len_got);
                break;
            end
            if (pos + len_got > got_bits.size()) break;
            val_got = '0;
            for (int b = 0; b < len_got; b++) begin
                val_got = {val_got[`MMSA_ACC_W-2:0], got_bits[pos]};
                pos++;
            end
            checks++;
            if (val_got != exp_sum[d]) begin
                errors++;
                $display("Fail %s diag %0d value: expected %h actual %h",
                         name, d, exp_sum[d], val_got);
            end
        end
    endtask

    task automatic run_index(input logic [1:0] xi, input logic [1:0] wi, input string tag);
        bit    ok;
        string name;
        name = $sformatf("%s x%0d w%0d", tag, xi, wi);
        build_expected(xi, wi);
        send_index(xi, wi);
        collect_frame(ok);
        if (ok) check_frame(name);
        repeat (2) step();
    endtask

    task automatic check_idle_outputs(input int cycles);
        for (int i = 0; i < cycles; i++) begin
            @(negedge clk);
            checks++;
            if (o_out_valid !== 1'b0 || o_out_value !== 1'b0) begin
                errors++;
                $display("Fail reset idle: expected 00 actual %b%b", o_out_valid, o_out_value);
            end
        end
    endtask

    // --------------------------------------------------
    // test sequence
    // --------------------------------------------------

    initial begin
        lfsr_state    = 32'd99;
        errors        = 0;
        checks        = 0;
        timeouts      = 0;
        neg_seen      = 0;
        zero_seen     = 0;
        cur_dim       = 2;
        n_diag        = 3;
        rst_n         = 1'b0;
        i_in_valid    = 1'b0;
        i_matrix      = 1'b0;
        i_matrix_size = 2'b00;
        i_in_valid2   = 1'b0;
        i_i_mat_idx   = 1'b0;
        i_w_mat_idx   = 1'b0;
        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;

        check_idle_outputs(20);

        // X0 forced to zero for the all-zero frame
        load_bank(2, 1'b1);
        run_index(2'd1, 2'd2, "2x2");
        run_index(2'd0, 2'd3, "2x2 zero");
        run_index(2'd3, 2'd0, "2x2");

        load_bank(4, 1'b0);
        run_index(2'(rand_bits(2)), 2'(rand_bits(2)), "4x4 random");
        run_index(2'd3, 2'd3, "4x4");
        run_index(2'd0, 2'd1, "4x4");
        run_index(2'd2, 2'd0, "4x4");

        // back to the small size after a full frame
        load_bank(2, 1'b0);
        run_index(2'd2, 2'd1, "2x2 reload");
        run_index(2'd0, 2'd0, "2x2 reload");

        if (neg_seen == 0) begin
            errors++;
            $display("Error: no negative diagonal sum was produced by the stimulus");
        end
        if (zero_seen == 0) begin
            errors++;
            $display("Error: no zero diagonal sum was produced by the stimulus");
        end

        $display("checks: %0d errors: %0d timeouts: %0d", checks, errors, timeouts);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: filelist.f
+incdir+src
src/mmsa_ctrl_pkg.sv
src/mmsa_data_pkg.sv
src/mmsa_load_decode.sv
src/mmsa_matrix_mem.sv
src/mmsa_diag_execute.sv
src/mmsa_result_serializer.sv
src/mmsa_top.sv
dv/mmsa_tb.sv

// File: src/mmsa_ctrl_pkg.sv
package mmsa_ctrl_pkg;

    // --------------------------------------------------
    // control encodings
    // --------------------------------------------------

    // low bit of the matrix size input
    typedef enum logic {
        SIZE_2X2 = 1'b0,
        SIZE_4X4 = 1'b1
    } size_e;

    // input phase tracking in decode
    typedef enum logic [1:0] {
        PH_IDLE    = 2'd0,
        PH_LOAD    = 2'd1,
        PH_INDEX   = 2'd2,
        PH_COMPUTE = 2'd3
    } phase_e;

    // serial output sequencing
    typedef enum logic [1:0] {
        OS_IDLE   = 2'd0,
        OS_LENGTH = 2'd1,
        OS_VALUE  = 2'd2
    } out_state_e;

endpackage

// File: src/mmsa_data_pkg.sv
`include "mmsa_macros.svh"

package mmsa_data_pkg;

    // signed matrix element
    typedef logic signed [`MMSA_ELEM_W-1:0] elem_t;

    // signed diagonal sum, wide enough for 4 products per diagonal entry
    typedef logic signed [`MMSA_ACC_W-1:0] acc_t;

    // bit length of a sum, 1 to 40
    typedef logic [`MMSA_LEN_W-1:0] len_t;

    // bank address, matrix index above element offset
    typedef logic [`MMSA_IDX_W+`MMSA_OFF_W-1:0] mem_addr_t;

endpackage

// File: src/mmsa_diag_execute.sv
`timescale 1ns/1ps
`include "mmsa_macros.svh"

module mmsa_diag_execute (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     i_start,
    input  logic [`MMSA_IDX_W-1:0]   i_x_sel,
    input  logic [`MMSA_IDX_W-1:0]   i_w_sel,
    input  mmsa_ctrl_pkg::size_e     i_size,
    input  mmsa_data_pkg::elem_t     i_x_rd_data,
    input  mmsa_data_pkg::elem_t     i_w_rd_data,
    output mmsa_data_pkg::mem_addr_t o_x_rd_addr,
    output mmsa_data_pkg::mem_addr_t o_w_rd_addr,
    output logic                     o_done,
    output mmsa_data_pkg::acc_t      o_diag [`MMSA_NUM_DIAGS],
    output mmsa_ctrl_pkg::size_e     o_size
);

    localparam int DIM_W  = $clog2(`MMSA_MAX_DIM);
    localparam int DIAG_W = $clog2(`MMSA_NUM_DIAGS);

    logic [`MMSA_IDX_W-1:0]         x_sel_q;
    logic [`MMSA_IDX_W-1:0]         w_sel_q;
    logic                           busy;
    logic [DIM_W-1:0]               r;
    logic [DIM_W-1:0]               c;
    logic [DIM_W-1:0]               k;
    logic [DIM_W-1:0]               last_idx;
    logic                           last_triple;
    logic                           rd_vld;
    logic                           rd_last;
    logic [DIAG_W-1:0]              rd_diag;
    logic signed [2*`MMSA_ELEM_W-1:0] prod;

    // --------------------------------------------------
    // triple sequencer with k innermost
    // --------------------------------------------------

    assign last_idx    = (o_size == mmsa_ctrl_pkg::SIZE_4X4) ?
                         DIM_W'(`MMSA_MAX_DIM - 1) : DIM_W'(1);
    assign last_triple = (r == last_idx) && (c == last_idx) && (k == last_idx);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy    <= 1'b0;
            r       <= '0;
            c       <= '0;
            k       <= '0;
            x_sel_q <= '0;
            w_sel_q <= '0;
            o_size  <= mmsa_ctrl_pkg::SIZE_2X2;
        end else if (i_start) begin
            busy    <= 1'b1;
            r       <= '0;
            c       <= '0;
            k       <= '0;
            x_sel_q <= i_x_sel;
            w_sel_q <= i_w_sel;
            o_size  <= i_size;
        end else if (busy) begin
            if (k == last_idx) begin
                k <= '0;
                if (c == last_idx) begin
                    c <= '0;
                    r <= r + 1'b1;
                end else begin
                    c <= c + 1'b1;
                end
            end else begin
                k <= k + 1'b1;
            end
            if (last_triple) begin
                busy <= 1'b0;
            end
        end
    end

    // X[r][k] and W[k][c]
    assign o_x_rd_addr = {x_sel_q, r, k};
    assign o_w_rd_addr = {w_sel_q, k, c};

    // --------------------------------------------------
    // read latency alignment and done
    // --------------------------------------------------

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_vld  <= 1'b0;
            rd_last <= 1'b0;
            rd_diag <= '0;
            o_done  <= 1'b0;
        end else begin
            rd_vld  <= busy;
            rd_last <= busy && last_triple;
            rd_diag <= DIAG_W'(r) + DIAG_W'(c);
            o_done  <= rd_last;
        end
    end

    // --------------------------------------------------
    // multiply-accumulate
    // --------------------------------------------------

    assign prod = i_x_rd_data * i_w_rd_data;

    // sums stay put after done until the next start
    always_ff @(posedge clk) begin
        if (i_start) begin
            for (int d = 0; d < `MMSA_NUM_DIAGS; d++) begin
                o_diag[d] <= '0;
            end
        end else if (rd_vld) begin
            o_diag[rd_diag] <= o_diag[rd_diag] + mmsa_data_pkg::acc_t'(prod);
        end
    end

endmodule

// File: src/mmsa_load_decode.sv
`timescale 1ns/1ps
`include "mmsa_macros.svh"

module mmsa_load_decode (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     i_in_valid,
    input  logic                     i_matrix,
    input  logic [1:0]               i_matrix_size,
    input  logic                     i_in_valid2,
    input  logic                     i_i_mat_idx,
    input  logic                     i_w_mat_idx,
    output logic                     o_wr_en,
    output logic                     o_wr_bank,
    output mmsa_data_pkg::mem_addr_t o_wr_addr,
    output mmsa_data_pkg::elem_t     o_wr_data,
    output logic [`MMSA_IDX_W-1:0]   o_x_sel,
    output logic [`MMSA_IDX_W-1:0]   o_w_sel,
    output mmsa_ctrl_pkg::size_e     o_size,
    output logic                     o_start
);

    localparam int BIT_CNT_W  = $clog2(`MMSA_ELEM_W);
    localparam int ELEM_CNT_W = $clog2(2 * `MMSA_NUM_MATS * `MMSA_MAX_DIM * `MMSA_MAX_DIM);

    mmsa_ctrl_pkg::phase_e   phase;
    logic                    load_start;
    logic [BIT_CNT_W-1:0]    bit_cnt;
    logic [ELEM_CNT_W-1:0]   elem_cnt;
    logic [`MMSA_ELEM_W-1:0] elem_sr;

    // --------------------------------------------------
    // phase control
    // --------------------------------------------------

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase <= mmsa_ctrl_pkg::PH_IDLE;
        end else begin
            case (phase)
                mmsa_ctrl_pkg::PH_IDLE: begin
                    if (i_in_valid) begin
                        phase <= mmsa_ctrl_pkg::PH_LOAD;
                    end else if (i_in_valid2) begin
                        phase <= mmsa_ctrl_pkg::PH_INDEX;
                    end
                end
                mmsa_ctrl_pkg::PH_LOAD: begin
                    if (!i_in_valid) begin
                        phase <= mmsa_ctrl_pkg::PH_IDLE;
                    end
                end
                mmsa_ctrl_pkg::PH_INDEX: begin
                    if (!i_in_valid2) begin
                        phase <= mmsa_ctrl_pkg::PH_COMPUTE;
                    end
                end
                default: phase <= mmsa_ctrl_pkg::PH_IDLE;
            endcase
        end
    end

    // single cycle, right after the index bits
    assign o_start = (phase == mmsa_ctrl_pkg::PH_COMPUTE);

    // first load cycle, seen before the phase catches up
    assign load_start = i_in_valid && (phase != mmsa_ctrl_pkg::PH_LOAD);

    // --------------------------------------------------
    // element deserializer
    // --------------------------------------------------

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bit_cnt  <= '0;
            elem_cnt <= '0;
            o_wr_en  <= 1'b0;
            o_size   <= mmsa_ctrl_pkg::SIZE_2X2;
        end else begin
            if (i_in_valid) begin
                bit_cnt <= bit_cnt + 1'b1;
            end else begin
                bit_cnt <= '0;
            end
            // write fires once all 16 bits are in
            o_wr_en <= i_in_valid && (bit_cnt == BIT_CNT_W'(`MMSA_ELEM_W - 1));
            if (load_start) begin
                elem_cnt <= '0;
                o_size   <= mmsa_ctrl_pkg::size_e'(i_matrix_size[0]);
            end else if (o_wr_en) begin
                elem_cnt <= elem_cnt + 1'b1;
            end
        end
    end

    // msb arrives first
    always_ff @(posedge clk) begin
        if (i_in_valid) begin
            elem_sr <= {elem_sr[`MMSA_ELEM_W-2:0], i_matrix};
        end
    end

    assign o_wr_data = elem_sr;

    // rows always stored with a stride of 4 so execute needs no size
    always_comb begin
        if (o_size == mmsa_ctrl_pkg::SIZE_4X4) begin
            o_wr_bank = elem_cnt[6];
            o_wr_addr = elem_cnt[5:0];
        end else begin
            o_wr_bank = elem_cnt[4];
            o_wr_addr = {elem_cnt[3:2], 1'b0, elem_cnt[1], 1'b0, elem_cnt[0]};
        end
    end

    // --------------------------------------------------
    // index deserializer
    // --------------------------------------------------

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            o_x_sel <= '0;
            o_w_sel <= '0;
        end else if (i_in_valid2) begin
            o_x_sel <= {o_x_sel[`MMSA_IDX_W-2:0], i_i_mat_idx};
            o_w_sel <= {o_w_sel[`MMSA_IDX_W-2:0], i_w_mat_idx};
        end
    end

endmodule

// File: src/mmsa_macros.svh
`ifndef MMSA_MACROS_SVH
`define MMSA_MACROS_SVH

// --------------------------------------------------
// data widths
// --------------------------------------------------

// one matrix element
`define MMSA_ELEM_W 16

// one anti-diagonal sum
`define MMSA_ACC_W 40

// bit-length field sent ahead of each sum
`define MMSA_LEN_W 6

// --------------------------------------------------
// bank geometry
// --------------------------------------------------

// matrices held per bank
`define MMSA_NUM_MATS 4
`define MMSA_IDX_W 2

// element offset inside one matrix slot
`define MMSA_OFF_W 4

`define MMSA_MAX_DIM 4
`define MMSA_NUM_DIAGS 7

`endif

// File: src/mmsa_matrix_mem.sv
`timescale 1ns/1ps
`include "mmsa_macros.svh"

module mmsa_matrix_mem (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     i_wr_en,
    input  logic                     i_wr_bank,
    input  mmsa_data_pkg::mem_addr_t i_wr_addr,
    input  mmsa_data_pkg::elem_t     i_wr_data,
    input  mmsa_data_pkg::mem_addr_t i_x_rd_addr,
    input  mmsa_data_pkg::mem_addr_t i_w_rd_addr,
    output mmsa_data_pkg::elem_t     o_x_rd_data,
    output mmsa_data_pkg::elem_t     o_w_rd_data
);

    localparam int DEPTH = `MMSA_NUM_MATS * `MMSA_MAX_DIM * `MMSA_MAX_DIM;

    mmsa_data_pkg::elem_t x_mem [DEPTH];
    mmsa_data_pkg::elem_t w_mem [DEPTH];

    // bank 0 holds X, bank 1 holds W
    always_ff @(posedge clk) begin
        if (i_wr_en) begin
            if (i_wr_bank) begin
                w_mem[i_wr_addr] <= i_wr_data;
            end else begin
                x_mem[i_wr_addr] <= i_wr_data;
            end
        end
    end

    // registered reads, one cycle latency
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            o_x_rd_data <= '0;
            o_w_rd_data <= '0;
        end else begin
            o_x_rd_data <= x_mem[i_x_rd_addr];
            o_w_rd_data <= w_mem[i_w_rd_addr];
        end
    end

endmodule

// File: src/mmsa_result_serializer.sv
`timescale 1ns/1ps
`include "mmsa_macros.svh"

module mmsa_result_serializer (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 i_done,
    input  mmsa_data_pkg::acc_t  i_diag [`MMSA_NUM_DIAGS],
    input  mmsa_ctrl_pkg::size_e i_size,
    output logic                 o_out_valid,
    output logic                 o_out_value
);

    localparam int DIAG_W = $clog2(`MMSA_NUM_DIAGS);
    localparam int LPOS_W = $clog2(`MMSA_LEN_W);

    mmsa_ctrl_pkg::out_state_e state;
    logic [DIAG_W-1:0]         diag_idx;
    logic [DIAG_W-1:0]         last_diag;
    mmsa_data_pkg::acc_t       cur_sum;
    mmsa_data_pkg::len_t       cur_len;
    mmsa_data_pkg::len_t       cnt;
    logic [LPOS_W-1:0]         len_pos;
    mmsa_data_pkg::len_t       val_pos;

    // highest set bit plus one and a zero sum takes one bit
    function automatic mmsa_data_pkg::len_t bit_length(input mmsa_data_pkg::acc_t value);
        mmsa_data_pkg::len_t len;
        len = 1;
        for (int i = 1; i < `MMSA_ACC_W; i++) begin
            if (value[i]) begin
                len = mmsa_data_pkg::len_t'(i + 1);
            end
        end
        return len;
    endfunction

    assign last_diag = (i_size == mmsa_ctrl_pkg::SIZE_4X4) ?
                       DIAG_W'(`MMSA_NUM_DIAGS - 1) : DIAG_W'(2);
    assign cur_sum   = i_diag[diag_idx];
    assign cur_len   = bit_length(cur_sum);

    // --------------------------------------------------
    // output sequencing
    // --------------------------------------------------

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= mmsa_ctrl_pkg::OS_IDLE;
            diag_idx <= '0;
            cnt      <= '0;
        end else begin
            case (state)
                mmsa_ctrl_pkg::OS_IDLE: begin
                    if (i_done) begin
                        state    <= mmsa_ctrl_pkg::OS_LENGTH;
                        diag_idx <= '0;
                        cnt      <= '0;
                    end
                end
                mmsa_ctrl_pkg::OS_LENGTH: begin
                    if (cnt == mmsa_data_pkg::len_t'(`MMSA_LEN_W - 1)) begin
                        state <= mmsa_ctrl_pkg::OS_VALUE;
                        cnt   <= '0;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                mmsa_ctrl_pkg::OS_VALUE: begin
                    if (cnt == cur_len - 1'b1) begin
                        cnt <= '0;
                        if (diag_idx == last_diag) begin
                            state <= mmsa_ctrl_pkg::OS_IDLE;
                        end else begin
                            state    <= mmsa_ctrl_pkg::OS_LENGTH;
                            diag_idx <= diag_idx + 1'b1;
                        end
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                default: state <= mmsa_ctrl_pkg::OS_IDLE;
            endcase
        end
    end

    // both fields go out msb first
    assign len_pos = LPOS_W'(`MMSA_LEN_W - 1) - cnt[LPOS_W-1:0];
    assign val_pos = cur_len - 1'b1 - cnt;

    assign o_out_valid = (state != mmsa_ctrl_pkg::OS_IDLE);

    always_comb begin
        case (state)
            mmsa_ctrl_pkg::OS_LENGTH: o_out_value = cur_len[len_pos];
            mmsa_ctrl_pkg::OS_VALUE:  o_out_value = cur_sum[val_pos];
            default:                  o_out_value = 1'b0;
        endcase
    end

endmodule

// File: src/mmsa_top.sv
`timescale 1ns/1ps
`include "mmsa_macros.svh"

module mmsa_top (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       i_in_valid,
    input  logic       i_matrix,
    input  logic [1:0] i_matrix_size,
    input  logic       i_in_valid2,
    input  logic       i_i_mat_idx,
    input  logic       i_w_mat_idx,
    output logic       o_out_valid,
    output logic       o_out_value
);

    // --------------------------------------------------
    // interconnect
    // --------------------------------------------------

    logic                     wr_en;
    logic                     wr_bank;
    mmsa_data_pkg::mem_addr_t wr_addr;
    mmsa_data_pkg::elem_t     wr_data;
    logic [`MMSA_IDX_W-1:0]   x_sel;
    logic [`MMSA_IDX_W-1:0]   w_sel;
    mmsa_ctrl_pkg::size_e     dec_size;
    logic                     start;
    mmsa_data_pkg::mem_addr_t x_rd_addr;
    mmsa_data_pkg::mem_addr_t w_rd_addr;
    mmsa_data_pkg::elem_t     x_rd_data;
    mmsa_data_pkg::elem_t     w_rd_data;
    logic                     done;
    mmsa_data_pkg::acc_t      diag [`MMSA_NUM_DIAGS];
    mmsa_ctrl_pkg::size_e     exe_size;

    mmsa_load_decode u_decode (
        .clk           (clk),
        .rst_n         (rst_n),
        .i_in_valid    (i_in_valid),
        .i_matrix      (i_matrix),
        .i_matrix_size (i_matrix_size),
        .i_in_valid2   (i_in_valid2),
        .i_i_mat_idx   (i_i_mat_idx),
        .i_w_mat_idx   (i_w_mat_idx),
        .o_wr_en       (wr_en),
        .o_wr_bank     (wr_bank),
        .o_wr_addr     (wr_addr),
        .o_wr_data     (wr_data),
        .o_x_sel       (x_sel),
        .o_w_sel       (w_sel),
        .o_size        (dec_size),
        .o_start       (start)
    );

    mmsa_matrix_mem u_mem (
        .clk         (clk),
        .rst_n       (rst_n),
        .i_wr_en     (wr_en),
        .i_wr_bank   (wr_bank),
        .i_wr_addr   (wr_addr),
        .i_wr_data   (wr_data),
        .i_x_rd_addr (x_rd_addr),
        .i_w_rd_addr (w_rd_addr),
        .o_x_rd_data (x_rd_data),
        .o_w_rd_data (w_rd_data)
    );

    mmsa_diag_execute u_execute (
        .clk         (clk),
        .rst_n       (rst_n),
        .i_start     (start),
        .i_x_sel     (x_sel),
        .i_w_sel     (w_sel),
        .i_size      (dec_size),
        .i_x_rd_data (x_rd_data),
        .i_w_rd_data (w_rd_data),
        .o_x_rd_addr (x_rd_addr),
        .o_w_rd_addr (w_rd_addr),
        .o_done      (done),
        .o_diag      (diag),
        .o_size      (exe_size)
    );

    mmsa_result_serializer u_result (
        .clk         (clk),
        .rst_n       (rst_n),
        .i_done      (done),
        .i_diag      (diag),
        .i_size      (exe_size),
        .o_out_valid (o_out_valid),
        .o_out_value (o_out_value)
    );

endmodule
